// File: project.f
+incdir+.
fetchPkg.sv
progCounter.sv
instrMem.sv
ctrlDecode.sv
hazardDetect.sv
issueStage.sv
fetch.sv
tb_fetch.sv

// File: Makefile
SRCS := fetch_defines.svh fetchPkg.sv progCounter.sv instrMem.sv ctrlDecode.sv \
        hazardDetect.sv issueStage.sv fetch.sv tb_fetch.sv

.PHONY: run clean

run: obj_dir/Vtb_fetch
	-./obj_dir/Vtb_fetch > sim.log 2>&1
	@cat sim.log
	@if grep -q "TB FAILED" sim.log; then exit 1; fi
	@grep -q "TB PASSED" sim.log

obj_dir/Vtb_fetch: project.f $(SRCS)
	verilator --binary --assert --timing --timescale 1ns/1ps \
		--top-module tb_fetch -f project.f

clean:
	rm -rf obj_dir sim.log

// File: tb_fetch.sv
// Programs load under reset and memory past each program keeps words from earlier tests
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module tb_fetch;

   import fetchPkg::*;

   localparam int MaxCycles = 1000;  // Five tests take about 110 cycles

   logic        clk;
   logic        reset;
   logic        redirectValid;
   logic [15:0] redirectTarget;
   logic        progWrEn;
   logic [7:0]  progAddr;
   logic [15:0] progData;
   issueWord_t  issue;
   logic        halted;

   string       testName;
   int          cycleCount = 0;
   logic [15:0] prog[$];
   logic [15:0] expPc[$];
   logic [15:0] expInstr[$];
   issueWord_t  got[$];       // Valid issues in arrival order
   int          gotCycle[$];  // Cycle of each valid issue

   fetch UUT (.clk(clk), .reset(reset), .redirectValid(redirectValid),
      .redirectTarget(redirectTarget), .progWrEn(progWrEn), .progAddr(progAddr),
      .progData(progData), .issue(issue), .halted(halted));

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= MaxCycles) begin
         $display("Timeout: tests still running after %0d cycles", cycleCount);
         $display("TB FAILED");
         $fatal(1, "Timeout");
      end
   end

   task automatic compare(input string what, input logic [63:0] expected,
                          input logic [63:0] actual);
      if (expected !== actual) begin
         $display("ERR %s %s expected %h actual %h", testName, what, expected, actual);
         $display("TB FAILED");
         $fatal(1, "Check failed");
      end
   endtask

   // Decode table written out from the opcode bit patterns
   function automatic ctrlWord_t modelCtrl(input logic [15:0] w);
      ctrlWord_t c;
      c = '0;
      case (w[15:11])
         5'b01000, 5'b01001: begin
            c.regWrite = 1'b1;
            c.aluImm   = 1'b1;
            c.destReg  = w[7:5];
         end
         5'b10001: begin
            c.memEnable = 1'b1;
            c.regWrite  = 1'b1;
            c.destReg   = w[7:5];
         end
         5'b10000: begin
            c.memEnable = 1'b1;
            c.memWrite  = 1'b1;
         end
         5'b11000: begin
            c.regWrite = 1'b1;
            c.destReg  = w[10:8];
         end
         5'b11011: begin
            c.regWrite = 1'b1;
            c.destReg  = w[4:2];
         end
         5'b01100, 5'b01101: c.isBranch = 1'b1;
         5'b00100, 5'b00101: c.isJump = 1'b1;
         5'b00110, 5'b00111: begin
            c.isJump   = 1'b1;
            c.link     = 1'b1;
            c.regWrite = 1'b1;
            c.destReg  = 3'd7;
         end
         5'b00000: c.halt = 1'b1;
         5'b00001: ;                  // NOP
         default:  c.ctrlErr = 1'b1;
      endcase
      return c;
   endfunction

   // No source ever hits a destination
   function automatic logic [15:0] randomWord();
      logic [2:0]  src;
      logic [2:0]  src2;
      logic [2:0]  dst;
      logic [15:0] w;
      src  = 3'($urandom % 4);      // Reads from r0..r3
      src2 = 3'($urandom % 4);
      dst  = 3'(4 + $urandom % 3);  // Writes r4..r6, JAL takes r7
      case ($urandom % 5)
         0:       w = {5'b01000, src, dst, 5'($urandom)};
         1:       w = {5'b11000, dst, 8'($urandom)};
         2:       w = {5'b10000, src, src2, 5'($urandom)};
         3:       w = {5'b00100, 11'($urandom)};
         default: w = {5'b00110, 11'($urandom)};
      endcase
      return w;
   endfunction

   // Starts and ends on a falling edge
   task automatic loadProgram();
      reset = 1'b1;
      foreach (prog[i]) begin
         progWrEn = 1'b1;
         progAddr = 8'(i);
         progData = prog[i];
         @(negedge clk);
      end
      progWrEn = 1'b0;
      repeat (3) @(negedge clk);
      compare("valid in reset", 64'(0), 64'(issue.valid));
      compare("halted in reset", 64'(0), 64'(halted));
      compare("ctrl in reset", 64'(0), 64'(issue.ctrl));
      compare("instr in reset", 64'(`FETCH_BUBBLE), 64'(issue.instr));
      reset = 1'b0;
   endtask

   task automatic runProgram(input int redirectAt, input int maxCycles);
      got.delete();
      gotCycle.delete();
      for (int c = 0; c < maxCycles; c++) begin
         redirectValid = (c == redirectAt);
         @(negedge clk);
         if (issue.valid) begin
            got.push_back(issue);
            gotCycle.push_back(c);
         end
         if (halted) begin
            // Halted must rise with the HALT issue itself
            compare("halted with HALT issue", 64'(1), 64'(issue.valid & issue.ctrl.halt));
            break;
         end
      end
      redirectValid = 1'b0;
   endtask

   task automatic checkStream();
      compare("issue count", 64'(expInstr.size()), 64'(got.size()));
      foreach (expInstr[i]) begin
         compare($sformatf("pc %0d", i), 64'(expPc[i]), 64'(got[i].pc));
         compare($sformatf("instr %0d", i), 64'(expInstr[i]), 64'(got[i].instr));
         compare($sformatf("ctrl %0d", i), 64'(modelCtrl(expInstr[i])), 64'(got[i].ctrl));
      end
      compare("halted at end", 64'(1), 64'(halted));
   endtask

   task automatic testReset();
      testName = "reset";
      prog = '{16'h0800, 16'h0000};  // NOP, HALT
      loadProgram();
      runProgram(-1, 20);
      expPc = '{16'h0000, 16'h0002};
      expInstr = prog;
      checkStream();
   endtask

   task automatic testInOrder();
      testName = "in order";
      prog.delete();
      expPc.delete();
      for (int i = 0; i < 12; i++) begin
         prog.push_back(randomWord());
         expPc.push_back(16'(2 * i));
      end
      prog.push_back(16'h0000);
      expPc.push_back(16'd24);
      loadProgram();
      runProgram(-1, 40);
      expInstr = prog;
      checkStream();
      foreach (gotCycle[i]) compare($sformatf("cycle %0d", i), 64'(i), 64'(gotCycle[i]));
   endtask

   task automatic testHazard();
      testName = "hazard";
      // ADDI r1, RTYPE reading r1, ADDI reading r5, HALT
      prog = '{16'h4023, 16'hD94C, 16'h45C1, 16'h0000};
      loadProgram();
      runProgram(-1, 30);
      expPc = '{16'h0000, 16'h0002, 16'h0004, 16'h0006};
      expInstr = prog;
      checkStream();
      compare("dependent gap", 64'(4), 64'(gotCycle[1] - gotCycle[0]));
      compare("independent gap", 64'(1), 64'(gotCycle[2] - gotCycle[1]));
   endtask

   task automatic testRedirect();
      testName = "redirect";
      prog = '{16'hC411, 16'hC522, 16'hC633};  // Third LBI gets dropped
      repeat (13) prog.push_back(16'h0800);
      prog.push_back(16'h4045);                // Target word at 0x20
      prog.push_back(16'h0000);
      redirectTarget = 16'h0020;
      loadProgram();
      runProgram(2, 30);                       // Pulse while PC is 4
      expPc = '{16'h0000, 16'h0002, 16'h0020, 16'h0022};
      expInstr = '{16'hC411, 16'hC522, 16'h4045, 16'h0000};
      checkStream();
      compare("redirect gap", 64'(2), 64'(gotCycle[2] - gotCycle[1]));
   endtask

   task automatic testCtrlErrHalt();
      ctrlWord_t errOnly;
      errOnly = '0;
      errOnly.ctrlErr = 1'b1;
      testName = "ctrl error and halt";
      prog = '{16'hF805, 16'h0000};  // Opcode 11111, then HALT
      loadProgram();
      runProgram(-1, 20);
      expPc = '{16'h0000, 16'h0002};
      expInstr = prog;
      checkStream();
      compare("error ctrl", 64'(errOnly), 64'(got[0].ctrl));
      repeat (20) begin
         @(negedge clk);
         compare("valid after halt", 64'(0), 64'(issue.valid));
         compare("halted held", 64'(1), 64'(halted));
      end
   endtask

   initial begin
      clk            = 1'b0;
      reset          = 1'b1;
      redirectValid  = 1'b0;
      redirectTarget = '0;
      progWrEn       = 1'b0;
      progAddr       = '0;
      progData       = '0;
      void'($urandom(32'h76f9_1c94));
      @(negedge clk);
      testReset();
      testInOrder();
      testHazard();
      testRedirect();
      testCtrlErrHalt();
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: fetch.sv
// Front end only and branches are resolved downstream and come back as a redirect
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch (
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               redirectValid,
   input  logic [`FETCH_DATA_W-1:0]           redirectTarget,
   input  logic                               progWrEn,
   input  logic [$clog2(`FETCH_MEM_WORDS)-1:0] progAddr,
   input  logic [`FETCH_DATA_W-1:0]           progData,
   output fetchPkg::issueWord_t               issue,
   output logic                               halted
);

   import fetchPkg::*;

   logic [`FETCH_DATA_W-1:0] pc;
   logic [`FETCH_DATA_W-1:0] instr;
   ctrlWord_t                ctrl;
   logic                     stall;
   logic                     pcHold;
   logic                     issuedWrite;
   logic [2:0]               issuedDest;

   progCounter uPc (.clk(clk), .reset(reset), .pcHold(pcHold),
      .redirectValid(redirectValid), .redirectTarget(redirectTarget), .pc(pc));

   instrMem uMem (.clk(clk), .addr(pc), .instr(instr),
      .progWrEn(progWrEn), .progAddr(progAddr), .progData(progData));

   // Decoder and hazard check look at the same fetched word
   ctrlDecode uDec (.instr(instr), .ctrl(ctrl));

   hazardDetect uHaz (.clk(clk), .reset(reset), .instr(instr),
      .issuedWrite(issuedWrite), .issuedDest(issuedDest), .stall(stall));

   issueStage uIss (.clk(clk), .reset(reset), .pc(pc), .instr(instr), .ctrl(ctrl),
      .stall(stall), .redirectValid(redirectValid), .pcHold(pcHold),
      .issuedWrite(issuedWrite), .issuedDest(issuedDest), .halted(halted),
      .issue(issue));

endmodule

`default_nettype wire

// File: issueStage.sv
// Issued destination is the value entering the issue register and halt holds until reset
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module issueStage (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [`FETCH_DATA_W-1:0] pc,
   input  logic [`FETCH_DATA_W-1:0] instr,
   input  fetchPkg::ctrlWord_t      ctrl,
   input  logic                     stall,
   input  logic                     redirectValid,
   output logic                     pcHold,
   output logic                     issuedWrite,
   output logic [2:0]               issuedDest,
   output logic                     halted,
   output fetchPkg::issueWord_t     issue
);

   import fetchPkg::*;

   logic       takeWord;
   issueWord_t nextIssue;

   // Redirect drops the word fetched this cycle
   assign takeWord = !stall && !redirectValid && !halted;

   always_comb begin
      nextIssue.valid = takeWord;
      nextIssue.pc    = pc;
      nextIssue.instr = takeWord ? instr : `FETCH_BUBBLE;
      nextIssue.ctrl  = takeWord ? ctrl : '0;
   end

   assign pcHold      = stall | halted;
   assign issuedWrite = nextIssue.ctrl.regWrite;  // Into scoreboard slot 0
   assign issuedDest  = nextIssue.ctrl.destReg;

   always_ff @(posedge clk) begin
      if (reset) begin
         issue  <= '{valid: 1'b0, pc: '0, instr: `FETCH_BUBBLE, ctrl: '0};
         halted <= 1'b0;
      end else begin
         issue <= nextIssue;
         if (takeWord && ctrl.halt) begin
            halted <= 1'b1;  // Rises with the HALT issue
         end
      end
   end

   // Halt freezes the PC unless a redirect comes in
   pcFrozenA: assert property (@(posedge clk) disable iff (reset)
      halted && !redirectValid |=> $stable(pc))
      else $error("PC moved while halted");

endmodule

`default_nettype wire

// File: hazardDetect.sv
// No forwarding is assumed so any read of an in-flight destination stalls the word
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module hazardDetect (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [`FETCH_DATA_W-1:0] instr,
   input  logic                     issuedWrite,
   input  logic [2:0]               issuedDest,
   output logic                     stall
);

   import fetchPkg::*;

   typedef struct packed {
      logic       valid;
      logic [2:0] dest;
   } sbSlot_t;

   sbSlot_t [`FETCH_SB_DEPTH-1:0] sb;  // Slot 0 is the youngest
   opcode_t                       op;
   logic                          readRs;
   logic                          readRt;

   assign op = opcode_t'(instr[15:11]);

   always_comb begin
      readRs = 1'b0;
      readRt = 1'b0;
      case (op)
         RTYPE, ST: begin
            readRs = 1'b1;
            readRt = 1'b1;
         end
         ADDI, SUBI, LD, BEQZ, BNEZ, JR, JALR: readRs = 1'b1;
         default: ;
      endcase
   end

   // Shifts every cycle, bubbles enter with valid low
   always_ff @(posedge clk) begin
      if (reset) begin
         sb <= '0;
      end else begin
         sb <= {sb[`FETCH_SB_DEPTH-2:0], sbSlot_t'{valid: issuedWrite, dest: issuedDest}};
      end
   end

   always_comb begin
      stall = 1'b0;
      for (int i = 0; i < `FETCH_SB_DEPTH; i++) begin
         if (sb[i].valid && ((readRs && sb[i].dest == instr[10:8]) ||
                             (readRt && sb[i].dest == instr[7:5]))) begin
            stall = 1'b1;
         end
      end
   end

   // A stalled word must enter the scoreboard as an empty slot
   stallNoWriteA: assert property (@(posedge clk) disable iff (reset) stall |-> !issuedWrite)
      else $error("Stalled word wrote the scoreboard");

endmodule

`default_nettype wire

// File: ctrlDecode.sv
// Purely combinational and destReg reads zero for words that do not write a register
`timescale 1ns/1ps
`default_nettype none

module ctrlDecode (
   input  logic [15:0]         instr,
   output fetchPkg::ctrlWord_t ctrl
);

   import fetchPkg::*;

   opcode_t   op;
   destSel_t  destSel;
   ctrlWord_t base;

   assign op = opcode_t'(instr[15:11]);

   // Opcode to control fields, destination picked below
   always_comb begin
      base    = '0;
      destSel = DEST_RD_I;              // I-type default, LD lands here
      case (op)
         ADDI, SUBI: begin
            base.regWrite = 1'b1;
            base.aluImm   = 1'b1;
         end
         LD: begin
            base.memEnable = 1'b1;
            base.regWrite  = 1'b1;
         end
         ST: begin
            base.memEnable = 1'b1;
            base.memWrite  = 1'b1;
         end
         LBI: begin
            base.regWrite = 1'b1;
            destSel       = DEST_RS;
         end
         RTYPE: begin
            base.regWrite = 1'b1;
            destSel       = DEST_RD_R;
         end
         BEQZ, BNEZ: base.isBranch = 1'b1;
         J, JR:      base.isJump   = 1'b1;
         JAL, JALR: begin
            base.isJump   = 1'b1;
            base.link     = 1'b1;
            base.regWrite = 1'b1;
            destSel       = DEST_R7;    // Return address
         end
         HALT: base.halt = 1'b1;
         NOP:  base      = '0;
         default: base.ctrlErr = 1'b1;  // Not a known opcode
      endcase
   end

   // Immediate format select is decided in execute and stays zero here
   always_comb begin
      ctrl = base;
      if (base.regWrite) begin
         case (destSel)
            DEST_RS:   ctrl.destReg = instr[10:8];
            DEST_RD_R: ctrl.destReg = instr[4:2];
            DEST_R7:   ctrl.destReg = 3'b111;
            DEST_RD_I: ctrl.destReg = instr[7:5];
         endcase
      end
   end

endmodule

`default_nettype wire

// File: instrMem.sv
// Contents are undefined until loaded and PC bit 0 plus bits above the index are ignored
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module instrMem (
   input  logic                               clk,
   input  logic [`FETCH_DATA_W-1:0]           addr,
   output logic [`FETCH_DATA_W-1:0]           instr,
   input  logic                               progWrEn,
   input  logic [$clog2(`FETCH_MEM_WORDS)-1:0] progAddr,
   input  logic [`FETCH_DATA_W-1:0]           progData
);

   localparam int IdxW = $clog2(`FETCH_MEM_WORDS);

   logic [`FETCH_DATA_W-1:0] mem [`FETCH_MEM_WORDS];
   logic [IdxW-1:0]          rdIdx;

   assign rdIdx = addr[IdxW:1];  // Byte address to word index
   assign instr = mem[rdIdx];    // Same-cycle read

   // Load port, used before a run
   always_ff @(posedge clk) begin
      if (progWrEn) begin
         mem[progAddr] <= progData;
      end
   end

endmodule

`default_nettype wire

// File: progCounter.sv
// Redirect targets must be even and a redirect still moves the PC after a halt
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module progCounter (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     pcHold,
   input  logic                     redirectValid,
   input  logic [`FETCH_DATA_W-1:0] redirectTarget,
   output logic [`FETCH_DATA_W-1:0] pc
);

   localparam int PcW = `FETCH_DATA_W;

   logic [PcW-1:0] pcNext;

   // Redirect beats hold, hold beats step
   always_comb begin
      if (redirectValid) begin
         pcNext = redirectTarget;
      end else if (pcHold) begin
         pcNext = pc;                  // Stall or halted
      end else begin
         pcNext = pc + PcW'(2);        // One 16-bit word
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else begin
         pc <= pcNext;
      end
   end

   // Odd PC means an odd redirect target got in from outside
   pcEvenA: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0)
      else $error("PC is odd: %h", pc);

endmodule

`default_nettype wire

// File: fetchPkg.sv
// Control word covers only the front end fields and unknown opcodes map to ctrlErr
`default_nettype none

`include "fetch_defines.svh"

package fetchPkg;

   typedef enum logic [4:0] {
      HALT  = 5'b00000,
      NOP   = 5'b00001,
      J     = 5'b00100,
      JR    = 5'b00101,
      JAL   = 5'b00110,
      JALR  = 5'b00111,
      ADDI  = 5'b01000,
      SUBI  = 5'b01001,
      BEQZ  = 5'b01100,
      BNEZ  = 5'b01101,
      ST    = 5'b10000,
      LD    = 5'b10001,
      LBI   = 5'b11000,
      RTYPE = 5'b11011
   } opcode_t;

   // Where the written register comes from
   typedef enum logic [1:0] {
      DEST_RS   = 2'b00,  // Bits 10..8
      DEST_RD_R = 2'b01,  // Bits 4..2
      DEST_R7   = 2'b10,
      DEST_RD_I = 2'b11   // Bits 7..5
   } destSel_t;

   typedef struct packed {
      logic       regWrite;
      logic [2:0] destReg;
      logic       memEnable;
      logic       memWrite;
      logic       aluImm;
      logic [2:0] immSel;
      logic       link;
      logic       isBranch;
      logic       isJump;
      logic       halt;
      logic       ctrlErr;
   } ctrlWord_t;

   typedef struct packed {
      logic                     valid;
      logic [`FETCH_DATA_W-1:0] pc;
      logic [`FETCH_DATA_W-1:0] instr;
      ctrlWord_t                ctrl;
   } issueWord_t;

endpackage

`default_nettype wire

// File: fetch_defines.svh
// Memory depth must stay a power of two and the PC is a byte address of 16-bit words
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

`define FETCH_DATA_W    16        // Instruction and PC width
`define FETCH_MEM_WORDS 256       // Index is PC bits 8..1
`define FETCH_SB_DEPTH  3         // In-flight destination slots
`define FETCH_BUBBLE    16'h0800  // NOP word

`endif
